// File: logic/router_pkg.sv
// shared types for the five-port 2D mesh wormhole router
// coordinates are 2 bits wide, so the mesh is at most 4x4
// a head flit carries its destination in the low bits of body
// port numbering doubles as the bit index of every port mask
package router_pkg;

  // mesh geometry and flit sizing
  localparam int unsigned CoordWidth   = 2;
  localparam int unsigned PayloadWidth = 32;
  localparam int unsigned NumPorts     = 5;

  // one X or Y coordinate
  typedef logic [CoordWidth-1:0] coord_t;

  // router position or packet destination
  typedef struct packed {
    coord_t x;
    coord_t y;
  } xy_t;

  // router ports, north is +y and east is +x
  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Local = 3'd4
  } port_e;

  // one bit per port
  // one-hot when used as a route, any pattern as a request set
  typedef logic [NumPorts-1:0] port_mask_t;

  // flit on every link
  // last marks the tail, head the first flit of a packet
  // a single-flit packet has both set
  typedef struct packed {
    logic                    last;
    logic                    head;
    logic [PayloadWidth-1:0] body;
  } flit_t;

  // one flit per port, indexed by port number
  typedef flit_t [NumPorts-1:0] flit_arr_t;

endpackage

// File: logic/flit_fifo.sv
// input flit buffer as a circular FIFO of Depth entries (Depth >= 1)
// the entry at the read pointer is offered at the output, so the
// Depth flits counted here include the one waiting to leave
// valid/ready on both sides and a flit moves when both are high
module flit_fifo #(
  parameter int unsigned Depth = 4
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              valid_i,
  output logic              ready_o,
  input  router_pkg::flit_t data_i,
  output logic              valid_o,
  input  logic              ready_i,
  output router_pkg::flit_t data_o
);
  import router_pkg::*;

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  // storage index and fill level
  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [CntWidth-1:0] cnt_t;

  flit_t mem_q [Depth];
  ptr_t  rd_ptr_q;
  ptr_t  wr_ptr_q;
  cnt_t  count_q;
  logic  push;
  logic  pop;

  // wrap at Depth, which need not be a power of two
  function automatic ptr_t ptr_inc(ptr_t ptr);
    if (ptr == ptr_t'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // full and empty straight from the count
  assign ready_o = (count_q != cnt_t'(Depth));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // simultaneous push and pop leaves the level alone
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // flit storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // a flit refused while full is still on offer next cycle
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_i && !ready_o |=> valid_i && $stable(data_i))
    else $error("flit_fifo: upstream withdrew a flit refused while full");

  // an empty FIFO has both pointers on the same entry
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !valid_o |-> rd_ptr_q == wr_ptr_q)
    else $error("flit_fifo: read and write pointers apart while empty");

endmodule

// File: logic/xy_route_select.sv
// XY route selection for one input port
// head flits route on the destination in body, X first and then Y
// body and tail flits reuse the route held since the head was popped
// +y is North and +x is East
module xy_route_select (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  router_pkg::xy_t        xy_id_i,
  input  logic                   valid_i,
  input  logic                   pop_i,
  input  router_pkg::flit_t      data_i,
  output router_pkg::port_mask_t route_o
);
  import router_pkg::*;

  xy_t        dst;
  port_e      head_port;
  port_mask_t head_route;
  port_mask_t route_q;

  // destination sits in the low body bits of a head flit
  assign dst = xy_t'(data_i.body[$bits(xy_t)-1:0]);

  // resolve x first, only then y
  always_comb begin
    if (dst.x > xy_id_i.x) begin
      head_port = East;
    end else if (dst.x < xy_id_i.x) begin
      head_port = West;
    end else if (dst.y > xy_id_i.y) begin
      head_port = North;
    end else if (dst.y < xy_id_i.y) begin
      head_port = South;
    end else begin
      head_port = Local;
    end
  end

  assign head_route = port_mask_t'(1) << head_port;

  // head flits decide here, the rest follow the held route
  assign route_o = (valid_i && data_i.head) ? head_route : route_q;

  // held route, live from head pop up to tail pop
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      route_q <= '0;
    end else if (pop_i) begin
      if (data_i.last) begin
        route_q <= '0;
      end else if (data_i.head) begin
        route_q <= head_route;
      end
    end
  end

  // body flit must follow a head from the same input
  a_body_has_route: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_i && !data_i.head |-> route_q != '0)
    else $error("xy_route_select: body flit arrived with no route held");

  // and a new head only after the previous tail
  a_head_after_tail: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_i && data_i.head |-> route_q == '0)
    else $error("xy_route_select: head flit arrived inside an open packet");

endmodule

// File: logic/wormhole_arbiter.sv
// round-robin wormhole arbiter for one output port
// a winning head flit locks the output to its input until the tail
// flit transfers; a stalled offer is held too, so valid_o and data_o
// stay put while ready_i is low
// priority after reset starts at North
module wormhole_arbiter (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  router_pkg::port_mask_t req_i,
  output router_pkg::port_mask_t ready_o,
  input  router_pkg::flit_arr_t  data_i,
  output logic                   valid_o,
  input  logic                   ready_i,
  output router_pkg::flit_t      data_o
);
  import router_pkg::*;

  port_e      rr_q;
  port_e      sel_q;
  port_e      win;
  port_e      sel;
  logic       found;
  logic       lock_q;
  logic       lock_d;
  logic       xfer;
  port_mask_t gnt;

  // first requester at or after rr_q going round the ring
  always_comb begin
    int unsigned idx;
    win   = rr_q;
    found = 1'b0;
    for (int unsigned off = 0; off < NumPorts; off++) begin
      idx = (rr_q + off) % NumPorts;
      if (!found && req_i[idx]) begin
        win   = port_e'(idx);
        found = 1'b1;
      end
    end
  end

  // locked input wins regardless of the others
  assign sel = lock_q ? sel_q : win;
  assign gnt = (lock_q || found) ? (port_mask_t'(1) << sel) : '0;

  // mux out the granted input
  assign valid_o = |(gnt & req_i);
  assign data_o  = data_i[sel];
  assign ready_o = gnt & {NumPorts{ready_i}};
  assign xfer    = valid_o & ready_i;

  // tail transfer frees the output
  // anything else on offer, or an open packet, keeps it
  always_comb begin
    if (xfer && data_o.last) begin
      lock_d = 1'b0;
    end else if (lock_q) begin
      lock_d = 1'b1;
    end else begin
      lock_d = valid_o;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q <= 1'b0;
      sel_q  <= North;
      rr_q   <= North;
    end else begin
      lock_q <= lock_d;
      // track the winner until a lock freezes it
      if (!lock_q) begin
        sel_q <= win;
      end
      // next packet starts its search one past this winner
      if (xfer && data_o.head) begin
        rr_q <= (sel == Local) ? North : port_e'(sel + 1'b1);
      end
    end
  end

  // free output with requests pending grants exactly one requester
  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !lock_q && req_i != '0 |-> $onehot(gnt & req_i))
    else $error("wormhole_arbiter: grant is not one-hot on the requests");

  // no switching inputs while the packet is open
  a_gnt_locked: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    lock_q |-> $stable(gnt))
    else $error("wormhole_arbiter: grant moved while locked");

endmodule

// File: logic/mesh_router.sv
// five-port wormhole router for a 2D XY mesh, ports N/E/S/W/Local
// one input FIFO of InFifoDepth flits per port, no output buffering
// traffic must follow XY order: a North/South input never turns to
// East/West and no input goes back out its own port; a packet routed
// that way is never accepted and blocks its input
module mesh_router #(
  parameter int unsigned InFifoDepth = 4
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  router_pkg::xy_t        xy_id_i,
  input  router_pkg::port_mask_t valid_i,
  output router_pkg::port_mask_t ready_o,
  input  router_pkg::flit_arr_t  data_i,
  output router_pkg::port_mask_t valid_o,
  input  router_pkg::port_mask_t ready_i,
  output router_pkg::flit_arr_t  data_o
);
  import router_pkg::*;

  // FIFO side of each input
  port_mask_t in_valid;
  port_mask_t in_ready;
  port_mask_t in_pop;
  flit_arr_t  in_data;

  // route[in][out], one-hot per input
  port_mask_t [NumPorts-1:0] route;
  // req[out][in] and arb_ready[out][in], arbiter side
  port_mask_t [NumPorts-1:0] req;
  port_mask_t [NumPorts-1:0] arb_ready;
  // in_ready_mat[in][out], the same readies seen from the input side
  port_mask_t [NumPorts-1:0] in_ready_mat;
  // arb_data[out][in]
  flit_arr_t  [NumPorts-1:0] arb_data;

  // input stage: buffer and route per port
  for (genvar p = 0; p < NumPorts; p++) begin : gen_input
    flit_fifo #(
      .Depth ( InFifoDepth )
    ) u_flit_fifo (
      .clk_i    ( clk_i       ),
      .arst_n_i ( arst_n_i    ),
      .valid_i  ( valid_i[p]  ),
      .ready_o  ( ready_o[p]  ),
      .data_i   ( data_i[p]   ),
      .valid_o  ( in_valid[p] ),
      .ready_i  ( in_ready[p] ),
      .data_o   ( in_data[p]  )
    );

    xy_route_select u_route_select (
      .clk_i    ( clk_i       ),
      .arst_n_i ( arst_n_i    ),
      .xy_id_i  ( xy_id_i     ),
      .valid_i  ( in_valid[p] ),
      .pop_i    ( in_pop[p]   ),
      .data_i   ( in_data[p]  ),
      .route_o  ( route[p]    )
    );

    // pop when the output picked by the route takes the flit
    assign in_ready[p] = |(in_ready_mat[p] & route[p]);
    assign in_pop[p]   = in_valid[p] & in_ready[p];
  end

  // crossbar links, loopback and Y->X turns left out
  for (genvar o = 0; o < NumPorts; o++) begin : gen_link_out
    for (genvar i = 0; i < NumPorts; i++) begin : gen_link_in
      localparam bit Loopback = (i == o);
      localparam bit YxTurn   = (i == int'(North) || i == int'(South)) &&
                                (o == int'(East) || o == int'(West));
      if (Loopback || YxTurn) begin : gen_tie_off
        assign req[o][i]          = 1'b0;
        assign arb_data[o][i]     = '0;
        assign in_ready_mat[i][o] = 1'b0;
      end else begin : gen_link
        assign req[o][i]          = in_valid[i] & route[i][o];
        assign arb_data[o][i]     = in_data[i];
        assign in_ready_mat[i][o] = arb_ready[o][i];
      end
    end
  end

  // output stage: one arbiter drives each port
  for (genvar o = 0; o < NumPorts; o++) begin : gen_output
    wormhole_arbiter u_wormhole_arbiter (
      .clk_i    ( clk_i        ),
      .arst_n_i ( arst_n_i     ),
      .req_i    ( req[o]       ),
      .ready_o  ( arb_ready[o] ),
      .data_i   ( arb_data[o]  ),
      .valid_o  ( valid_o[o]   ),
      .ready_i  ( ready_i[o]   ),
      .data_o   ( data_o[o]    )
    );

    // stalled output keeps its flit, FIFO head and arbiter hold together
    a_out_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      valid_o[o] && !ready_i[o] |=> valid_o[o] && $stable(data_o[o]))
      else $error("mesh_router: output %0d changed while stalled", o);
  end

endmodule

// File: dv/tb_flit_gen.svh
// stimulus helpers for the router testbench, included in the tb module
// needs router_pkg imported by the including module first
// flit body: source port in the top 3 bits, destination in [3:0] of a head
`ifndef TB_FLIT_GEN_SVH
`define TB_FLIT_GEN_SVH

// LCG state, fixed seed
logic [31:0] lcg_state = 32'h6e0;

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// low bits of an LCG are weak, use the upper ones
function automatic int unsigned rand_range(int unsigned lo, int unsigned hi);
  return lo + ((lcg_next() >> 8) % (hi - lo + 1));
endfunction

// XY order: x first, then y, Local when both match
function automatic port_e expected_port(xy_t own, xy_t dst);
  if (dst.x > own.x) return East;
  if (dst.x < own.x) return West;
  if (dst.y > own.y) return North;
  if (dst.y < own.y) return South;
  return Local;
endfunction

// no loopback, no turn from Y into X
function automatic bit legal_link(port_e src, port_e out);
  bit y_in;
  bit x_out;
  y_in  = (src == North) || (src == South);
  x_out = (out == East) || (out == West);
  return (src != out) && !(y_in && x_out);
endfunction

// random destination that this input may legally reach
function automatic xy_t rand_dst(port_e src, xy_t own);
  xy_t d;
  repeat (64) begin
    d.x = coord_t'(lcg_next() >> 13);
    d.y = coord_t'(lcg_next() >> 13);
    if (legal_link(src, expected_port(own, d))) return d;
  end
  // own position routes to Local, legal for any non-Local input
  return own;
endfunction

function automatic flit_t make_flit(port_e src, xy_t dst, bit head, bit last);
  flit_t f;
  f.last = last;
  f.head = head;
  f.body = lcg_next();
  f.body[PayloadWidth-1 -: 3] = src;
  if (head) f.body[$bits(xy_t)-1:0] = dst;
  return f;
endfunction

`endif

// File: dv/tb_mesh_router.sv
// testbench for mesh_router placed at (1,1) of the mesh
// traffic keeps to legal XY links only, illegal ones block an input
// each flit carries its source port, the scoreboard keys on it
module tb_mesh_router;
  timeunit 1ns;
  timeprecision 1ps;
  import router_pkg::*;
  `include "tb_flit_gen.svh"

  localparam int unsigned InFifoDepth   = 4;
  localparam int unsigned MaxLen        = 6;
  localparam int unsigned SrcLsb        = PayloadWidth - 3;
  localparam int unsigned DrainCycles   = 400;
  // tests 2 to 5: 9 singles, 3x4 and 2x6 packets, one stalled packet
  localparam int unsigned TotalFlits    = 9 + 12 * MaxLen + 12 * MaxLen + InFifoDepth + 3;
  localparam int unsigned WatchdogCycles = TotalFlits * 50 + 1000;

  logic       clk;
  logic       arst_n;
  xy_t        xy_id;
  port_mask_t in_valid;
  port_mask_t in_ready;
  flit_arr_t  in_data;
  port_mask_t out_valid;
  port_mask_t out_ready;
  flit_arr_t  out_data;

  // scoreboard, expected flits per output and source
  flit_t       exp_q [NumPorts][NumPorts][$];
  port_e       cur_route [NumPorts];
  logic        pkt_open [NumPorts];
  logic [2:0]  pkt_src [NumPorts];
  int unsigned pending;
  int unsigned checked;
  int unsigned errors;
  int unsigned ntests;
  // fairness and back-pressure bookkeeping
  logic        fair_mode;
  logic        fair_have;
  logic [2:0]  fair_last;
  logic        bp_mode;
  int unsigned bp_accepted;

  mesh_router #(
    .InFifoDepth ( InFifoDepth )
  ) mesh_router_i (
    .clk_i    ( clk       ),
    .arst_n_i ( arst_n    ),
    .xy_id_i  ( xy_id     ),
    .valid_i  ( in_valid  ),
    .ready_o  ( in_ready  ),
    .data_i   ( in_data   ),
    .valid_o  ( out_valid ),
    .ready_i  ( out_ready ),
    .data_o   ( out_data  )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // input side records, output side compares
  always @(posedge clk) begin
    flit_t      got;
    flit_t      want;
    logic [2:0] src;
    if (arst_n) begin
      for (int p = 0; p < NumPorts; p++) begin
        if (in_valid[p] && in_ready[p]) begin
          if (in_data[p].head) begin
            cur_route[p] = expected_port(xy_id, xy_t'(in_data[p].body[3:0]));
          end
          exp_q[cur_route[p]][p].push_back(in_data[p]);
          pending++;
          if (bp_mode && p == East) bp_accepted++;
        end
      end
      for (int o = 0; o < NumPorts; o++) begin
        if (out_valid[o] && out_ready[o]) begin
          got = out_data[o];
          src = got.body[SrcLsb +: 3];
          checked++;
          if (src >= NumPorts || exp_q[o][src].size() == 0) begin
            errors++;
            $display("unexpected flit %h at output %0d, nothing was sent there", got, o);
          end else begin
            want = exp_q[o][src].pop_front();
            pending--;
            assert (got == want) else begin
              errors++;
              $display("Mismatch data_o[%0d]: expected %h got %h", o, want, got);
            end
          end
          // wormhole: one source per open packet
          assert (!pkt_open[o] || src == pkt_src[o]) else begin
            errors++;
            $display("Mismatch data_o[%0d] source: expected %h got %h", o, pkt_src[o], src);
          end
          assert (pkt_open[o] || got.head) else begin
            errors++;
            $display("output %0d sent a body flit with no packet open", o);
          end
          if (fair_mode && o == Local && got.head) begin
            fair_last = src;
            fair_have = 1'b1;
          end
          if (got.last) begin
            pkt_open[o] = 1'b0;
          end else if (got.head) begin
            pkt_open[o] = 1'b1;
            pkt_src[o]  = src;
          end
        end
      end
    end
  end

  // idle outputs and empty FIFOs in and right after reset
  a_reset_state: assert property (@(posedge clk)
    (!arst_n || $rose(arst_n)) |-> out_valid == '0 && in_ready == '1)
    else begin
      errors++;
      $display("Mismatch valid_o/ready_o in reset: valid_o %h ready_o %h", out_valid, in_ready);
    end

  // E and W take turns at Local
  a_fair_turns: assert property (@(posedge clk) disable iff (!arst_n)
    fair_mode && fair_have && out_valid[Local] && out_ready[Local] && out_data[Local].head
    |-> out_data[Local].body[SrcLsb +: 3] != fair_last)
    else begin
      errors++;
      $display("Mismatch Local head source: previous %h got %h", fair_last,
               out_data[Local].body[SrcLsb +: 3]);
    end

  // stalled East input fills its FIFO, then refuses
  a_fill_depth: assert property (@(posedge clk) disable iff (!arst_n)
    bp_mode && $fell(in_ready[East]) |-> bp_accepted == InFifoDepth)
    else begin
      errors++;
      $display("Mismatch flits taken before ready_o[1] fell: expected %h got %h",
               InFifoDepth, bp_accepted);
    end

  for (genvar o = 0; o < NumPorts; o++) begin : gen_out_check
    a_hold_stalled: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid[o] && !out_ready[o] |=> out_valid[o] && $stable(out_data[o]))
      else begin
        errors++;
        $display("Mismatch data_o[%0d] moved while stalled: valid_o %h data_o %h",
                 o, out_valid[o], out_data[o]);
      end
  end

  // entered on a falling edge, returns on the one after the transfer
  task automatic send_flit(port_e p, flit_t f);
    in_valid[p] = 1'b1;
    in_data[p]  = f;
    // ready_o hangs on FIFO state only, settled here
    while (!in_ready[p]) @(negedge clk);
    @(negedge clk);
  endtask

  task automatic send_packet(port_e src, xy_t dst, int unsigned len);
    for (int unsigned i = 0; i < len; i++) begin
      send_flit(src, make_flit(src, dst, i == 0, i == len - 1));
    end
  endtask

  task automatic release_port(port_e p);
    in_valid[p] = 1'b0;
  endtask

  task automatic wait_drain();
    int unsigned n;
    n = 0;
    while (pending != 0 && n < DrainCycles) begin
      @(negedge clk);
      n++;
    end
    if (pending != 0) begin
      errors++;
      $display("%0d flits never left the router within %0d cycles", pending, DrainCycles);
    end
  endtask

  task automatic finish_test(string name, int unsigned mark);
    ntests++;
    $display("test %-10s %s, %0d errors", name, (errors == mark) ? "ok" : "BAD",
             errors - mark);
  endtask

  task automatic end_run();
    $display("tests %0d, flits checked %0d, errors %0d", ntests, checked, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    errors++;
    $display("timeout after %0d cycles, the run did not finish", WatchdogCycles);
    end_run();
  end

  initial begin
    int unsigned mark;
    int unsigned n;
    xy_t         dst;
    port_e       src;
    arst_n    = 1'b0;
    xy_id     = '{x: 2'd1, y: 2'd1};
    in_valid  = '0;
    in_data   = '0;
    out_ready = '1;
    pending   = 0;
    checked   = 0;
    errors    = 0;
    ntests    = 0;
    fair_mode = 1'b0;
    fair_have = 1'b0;
    bp_mode   = 1'b0;
    for (int p = 0; p < NumPorts; p++) begin
      pkt_open[p]  = 1'b0;
      cur_route[p] = Local;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    finish_test("reset", 0);

    // single flits to the 3x3 block, center via North
    mark = errors;
    for (int k = 0; k < 9; k++) begin
      dst.x = coord_t'(k % 3);
      dst.y = coord_t'(k / 3);
      src   = (dst == xy_id) ? North : Local;
      send_packet(src, dst, 1);
      release_port(src);
    end
    wait_drain();
    finish_test("xy_route", mark);

    // three inputs fighting over North
    mark = errors;
    fork
      begin
        for (int k = 0; k < 4; k++) begin
          send_packet(East, '{x: 2'd1, y: coord_t'(rand_range(2, 3))}, rand_range(2, MaxLen));
        end
        release_port(East);
      end
      begin
        for (int k = 0; k < 4; k++) begin
          send_packet(West, '{x: 2'd1, y: coord_t'(rand_range(2, 3))}, rand_range(2, MaxLen));
        end
        release_port(West);
      end
      begin
        for (int k = 0; k < 4; k++) begin
          send_packet(South, rand_dst(South, xy_id), rand_range(2, MaxLen));
        end
        release_port(South);
      end
    join
    wait_drain();
    finish_test("wormhole", mark);

    // E and W stream into Local without gaps
    mark = errors;
    fair_mode = 1'b1;
    fork
      begin
        for (int k = 0; k < 6; k++) send_packet(East, xy_id, rand_range(2, MaxLen));
        release_port(East);
      end
      begin
        for (int k = 0; k < 6; k++) send_packet(West, xy_id, rand_range(2, MaxLen));
        release_port(West);
      end
    join
    wait_drain();
    fair_mode = 1'b0;
    finish_test("fairness", mark);

    // Local output stalled, East input must fill and stop
    mark = errors;
    out_ready[Local] = 1'b0;
    bp_accepted      = 0;
    bp_mode          = 1'b1;
    fork
      begin
        send_packet(East, xy_id, InFifoDepth + 3);
        release_port(East);
      end
      begin
        n = 0;
        while (in_ready[East] && n < 100) begin
          @(negedge clk);
          n++;
        end
        if (in_ready[East]) begin
          errors++;
          $display("ready_o of the stalled East input never fell");
        end
        repeat (8) @(negedge clk);
        out_ready[Local] = 1'b1;
      end
    join
    wait_drain();
    bp_mode = 1'b0;
    finish_test("backpress", mark);

    end_run();
  end

endmodule

// File: project.f
+incdir+dv
logic/router_pkg.sv
logic/flit_fifo.sv
logic/xy_route_select.sv
logic/wormhole_arbiter.sv
logic/mesh_router.sv
dv/tb_mesh_router.sv

// File: Bender.yml
package:
  name: mesh_router

sources:
  - files:
      - logic/router_pkg.sv
      - logic/flit_fifo.sv
      - logic/xy_route_select.sv
      - logic/wormhole_arbiter.sv
      - logic/mesh_router.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_mesh_router.sv
